//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- design/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module execute (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               de_valid_i,
   input  exu_pkg::data_t     de_pc_i,
   input  exu_pkg::data_t     de_imm_i,
   input  exu_pkg::data_t     de_rs1_data_i,
   input  exu_pkg::data_t     de_rs2_data_i,
   input  exu_pkg::reg_addr_t de_rs1_addr_i,
   input  exu_pkg::reg_addr_t de_rs2_addr_i,
   input  exu_pkg::reg_addr_t de_rd_i,
   input  exu_pkg::alu_op_t   de_alu_op_i,
   input  logic               de_opr1_pc_i,
   input  logic               de_opr2_imm_i,
   input  logic               de_rd_wr_i,
   input  logic               de_branch_i,
   input  logic               de_jump_i,
   input  logic               de_illegal_i,
   input  exu_pkg::br_op_t    de_br_op_i,
   output logic               wb_valid_o,
   output exu_pkg::reg_addr_t wb_rd_o,
   output exu_pkg::data_t     wb_data_o,
   output logic               redirect_valid_o,
   output exu_pkg::data_t     redirect_pc_o,
   output logic               illegal_o
);

   exu_pkg::data_t rs1_fwd;
   exu_pkg::data_t rs2_fwd;
   exu_pkg::data_t opr1;
   exu_pkg::data_t opr2;
   exu_pkg::data_t adder_out;
   exu_pkg::data_t alu_result;
   exu_pkg::data_t link_pc;
   exu_pkg::data_t target_pc;
   logic [`XLEN:0] cmp_diff;
   logic [4:0]     shamt;
   logic           signed_cmp;
   logic           is_less;
   logic           is_equal;
   logic           br_taken;

   // wb_valid_o already excludes x0, so a match is always safe
   assign rs1_fwd = (wb_valid_o && (wb_rd_o == de_rs1_addr_i)) ? wb_data_o : de_rs1_data_i;
   assign rs2_fwd = (wb_valid_o && (wb_rd_o == de_rs2_addr_i)) ? wb_data_o : de_rs2_data_i;

   assign opr1 = de_opr1_pc_i  ? de_pc_i  : rs1_fwd;
   assign opr2 = de_opr2_imm_i ? de_imm_i : rs2_fwd;

   assign adder_out = (de_alu_op_i == exu_pkg::ALU_SUB) ? (opr1 - opr2) : (opr1 + opr2);

   // Branches leave both selects clear, so opr1/opr2 are rs1/rs2 here
   assign signed_cmp = (de_alu_op_i == exu_pkg::ALU_SLT) ||
                       (de_branch_i && ((de_br_op_i == exu_pkg::BR_BLT) ||
                                        (de_br_op_i == exu_pkg::BR_BGE)));
   assign cmp_diff   = {signed_cmp & opr1[`XLEN-1], opr1} - {signed_cmp & opr2[`XLEN-1], opr2};
   assign is_less    = cmp_diff[`XLEN];          // Borrow or sign of the wide difference
   assign is_equal   = (opr1 == opr2);

   assign shamt = opr2[4:0];

   always_comb begin
      case (de_alu_op_i)
         exu_pkg::ALU_ADD,
         exu_pkg::ALU_SUB:   alu_result = adder_out;
         exu_pkg::ALU_AND:   alu_result = opr1 & opr2;
         exu_pkg::ALU_OR:    alu_result = opr1 | opr2;
         exu_pkg::ALU_XOR:   alu_result = opr1 ^ opr2;
         exu_pkg::ALU_SLL:   alu_result = opr1 << shamt;
         exu_pkg::ALU_SRL:   alu_result = opr1 >> shamt;
         exu_pkg::ALU_SRA:   alu_result = $signed(opr1) >>> shamt;
         exu_pkg::ALU_SLT,
         exu_pkg::ALU_SLTU:  alu_result = {{(`XLEN-1){1'b0}}, is_less};
         exu_pkg::ALU_PASS2: alu_result = opr2;
         default:            alu_result = '0;
      endcase
   end

   always_comb begin
      case (de_br_op_i)
         exu_pkg::BR_BEQ:  br_taken = is_equal;
         exu_pkg::BR_BNE:  br_taken = !is_equal;
         exu_pkg::BR_BLT,
         exu_pkg::BR_BLTU: br_taken = is_less;
         exu_pkg::BR_BGE,
         exu_pkg::BR_BGEU: br_taken = !is_less;
         default:          br_taken = 1'b0;
      endcase
   end

   assign link_pc   = de_pc_i + 32'd4;
   assign target_pc = de_pc_i + de_imm_i;       // Shared by JAL and branches

   // Result register, also the register file write port
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wb_valid_o       <= 1'b0;
         redirect_valid_o <= 1'b0;
         illegal_o        <= 1'b0;
      end else begin
         wb_valid_o       <= de_valid_i && de_rd_wr_i && (de_rd_i != '0);
         redirect_valid_o <= de_valid_i && (de_jump_i || (de_branch_i && br_taken));
         illegal_o        <= de_valid_i && de_illegal_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (de_valid_i) begin
         wb_rd_o       <= de_rd_i;
         wb_data_o     <= de_jump_i ? link_pc : alu_result;
         redirect_pc_o <= target_pc;
      end
   end

endmodule

`default_nettype wire

//--- design/exu_pkg.sv
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

   typedef logic [`XLEN-1:0]    data_t;        // Operands, results, immediates, PCs
   typedef logic [31:0]         instr_t;
   typedef logic [`REG_AW-1:0]  reg_addr_t;
   typedef logic [`ALU_OPW-1:0] alu_op_t;
   typedef logic [2:0]          br_op_t;       // Branch funct3

   // ALU operations
   localparam alu_op_t ALU_ADD   = 4'd0;
   localparam alu_op_t ALU_SUB   = 4'd1;
   localparam alu_op_t ALU_AND   = 4'd2;
   localparam alu_op_t ALU_OR    = 4'd3;
   localparam alu_op_t ALU_XOR   = 4'd4;
   localparam alu_op_t ALU_SLL   = 4'd5;
   localparam alu_op_t ALU_SRL   = 4'd6;
   localparam alu_op_t ALU_SRA   = 4'd7;
   localparam alu_op_t ALU_SLT   = 4'd8;
   localparam alu_op_t ALU_SLTU  = 4'd9;
   localparam alu_op_t ALU_PASS2 = 4'd10;      // LUI passes the immediate

   // Branch conditions, straight from funct3
   localparam br_op_t BR_BEQ  = 3'b000;
   localparam br_op_t BR_BNE  = 3'b001;
   localparam br_op_t BR_BLT  = 3'b100;
   localparam br_op_t BR_BGE  = 3'b101;
   localparam br_op_t BR_BLTU = 3'b110;
   localparam br_op_t BR_BGEU = 3'b111;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   // ALU funct3 / funct7
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_ALT     = 7'b0100000;   // SUB and SRA

endpackage

`default_nettype wire

//--- design/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               instr_valid_i,
   input  exu_pkg::instr_t    instr_i,
   input  exu_pkg::data_t     pc_i,
   output logic               wb_valid_o,
   output exu_pkg::reg_addr_t wb_rd_o,
   output exu_pkg::data_t     wb_data_o,
   output logic               redirect_valid_o,
   output exu_pkg::data_t     redirect_pc_o,
   output logic               illegal_o
);

   exu_pkg::reg_addr_t rs1_addr;
   exu_pkg::reg_addr_t rs2_addr;
   exu_pkg::data_t     rs1_data;
   exu_pkg::data_t     rs2_data;

   // Decode/execute stage
   logic               de_valid;
   exu_pkg::data_t     de_pc;
   exu_pkg::data_t     de_imm;
   exu_pkg::data_t     de_rs1_data;
   exu_pkg::data_t     de_rs2_data;
   exu_pkg::reg_addr_t de_rs1_addr;
   exu_pkg::reg_addr_t de_rs2_addr;
   exu_pkg::reg_addr_t de_rd;
   exu_pkg::alu_op_t   de_alu_op;
   logic               de_opr1_pc;
   logic               de_opr2_imm;
   logic               de_rd_wr;
   logic               de_branch;
   logic               de_jump;
   logic               de_illegal;
   exu_pkg::br_op_t    de_br_op;

   instr_decode u_decode (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .rs1_addr_o    (rs1_addr),
      .rs2_addr_o    (rs2_addr),
      .rs1_data_i    (rs1_data),
      .rs2_data_i    (rs2_data),
      .de_valid_o    (de_valid),
      .de_pc_o       (de_pc),
      .de_imm_o      (de_imm),
      .de_rs1_data_o (de_rs1_data),
      .de_rs2_data_o (de_rs2_data),
      .de_rs1_addr_o (de_rs1_addr),
      .de_rs2_addr_o (de_rs2_addr),
      .de_rd_o       (de_rd),
      .de_alu_op_o   (de_alu_op),
      .de_opr1_pc_o  (de_opr1_pc),
      .de_opr2_imm_o (de_opr2_imm),
      .de_rd_wr_o    (de_rd_wr),
      .de_branch_o   (de_branch),
      .de_jump_o     (de_jump),
      .de_illegal_o  (de_illegal),
      .de_br_op_o    (de_br_op)
   );

   // Written from the retire outputs
   reg_file u_rf (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rd_addr_a_i (rs1_addr),
      .rd_addr_b_i (rs2_addr),
      .rd_data_a_o (rs1_data),
      .rd_data_b_o (rs2_data),
      .wr_en_i     (wb_valid_o),
      .wr_addr_i   (wb_rd_o),
      .wr_data_i   (wb_data_o)
   );

   execute u_exec (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .de_valid_i       (de_valid),
      .de_pc_i          (de_pc),
      .de_imm_i         (de_imm),
      .de_rs1_data_i    (de_rs1_data),
      .de_rs2_data_i    (de_rs2_data),
      .de_rs1_addr_i    (de_rs1_addr),
      .de_rs2_addr_i    (de_rs2_addr),
      .de_rd_i          (de_rd),
      .de_alu_op_i      (de_alu_op),
      .de_opr1_pc_i     (de_opr1_pc),
      .de_opr2_imm_i    (de_opr2_imm),
      .de_rd_wr_i       (de_rd_wr),
      .de_branch_i      (de_branch),
      .de_jump_i        (de_jump),
      .de_illegal_i     (de_illegal),
      .de_br_op_i       (de_br_op),
      .wb_valid_o       (wb_valid_o),
      .wb_rd_o          (wb_rd_o),
      .wb_data_o        (wb_data_o),
      .redirect_valid_o (redirect_valid_o),
      .redirect_pc_o    (redirect_pc_o),
      .illegal_o        (illegal_o)
   );

endmodule

`default_nettype wire

//--- design/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               instr_valid_i,
   input  exu_pkg::instr_t    instr_i,
   input  exu_pkg::data_t     pc_i,
   output exu_pkg::reg_addr_t rs1_addr_o,
   output exu_pkg::reg_addr_t rs2_addr_o,
   input  exu_pkg::data_t     rs1_data_i,
   input  exu_pkg::data_t     rs2_data_i,
   output logic               de_valid_o,
   output exu_pkg::data_t     de_pc_o,
   output exu_pkg::data_t     de_imm_o,
   output exu_pkg::data_t     de_rs1_data_o,
   output exu_pkg::data_t     de_rs2_data_o,
   output exu_pkg::reg_addr_t de_rs1_addr_o,
   output exu_pkg::reg_addr_t de_rs2_addr_o,
   output exu_pkg::reg_addr_t de_rd_o,
   output exu_pkg::alu_op_t   de_alu_op_o,
   output logic               de_opr1_pc_o,
   output logic               de_opr2_imm_o,
   output logic               de_rd_wr_o,
   output logic               de_branch_o,
   output logic               de_jump_o,
   output logic               de_illegal_o,
   output exu_pkg::br_op_t    de_br_op_o
);

   logic [6:0]       opcode;
   logic [2:0]       funct3;
   logic [6:0]       funct7;
   exu_pkg::data_t   imm_i_type;
   exu_pkg::data_t   imm_u_type;
   exu_pkg::data_t   imm_b_type;
   exu_pkg::data_t   imm_j_type;
   exu_pkg::alu_op_t base_op;
   exu_pkg::alu_op_t alt_op;
   logic             has_alt;
   exu_pkg::alu_op_t alu_op;
   exu_pkg::data_t   imm;
   logic             opr1_pc;
   logic             opr2_imm;
   logic             rd_wr;
   logic             branch;
   logic             jump;
   logic             illegal;

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // Register file read straight from the incoming word
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_u_type = {instr_i[31:12], 12'b0};
   assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
   assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

   // funct3 to ALU op with funct7 clear
   always_comb begin
      case (funct3)
         exu_pkg::F3_ADD_SUB: base_op = exu_pkg::ALU_ADD;
         exu_pkg::F3_SLL:     base_op = exu_pkg::ALU_SLL;
         exu_pkg::F3_SLT:     base_op = exu_pkg::ALU_SLT;
         exu_pkg::F3_SLTU:    base_op = exu_pkg::ALU_SLTU;
         exu_pkg::F3_XOR:     base_op = exu_pkg::ALU_XOR;
         exu_pkg::F3_SRL_SRA: base_op = exu_pkg::ALU_SRL;
         exu_pkg::F3_OR:      base_op = exu_pkg::ALU_OR;
         default:             base_op = exu_pkg::ALU_AND;
      endcase
   end

   // Only ADD and SRL have a funct7 alternate
   assign has_alt = (funct3 == exu_pkg::F3_ADD_SUB) || (funct3 == exu_pkg::F3_SRL_SRA);
   assign alt_op  = (funct3 == exu_pkg::F3_ADD_SUB) ? exu_pkg::ALU_SUB : exu_pkg::ALU_SRA;

   always_comb begin
      alu_op   = exu_pkg::ALU_ADD;
      imm      = imm_i_type;
      opr1_pc  = 1'b0;
      opr2_imm = 1'b0;
      rd_wr    = 1'b0;
      branch   = 1'b0;
      jump     = 1'b0;
      illegal  = 1'b0;
      case (opcode)
         exu_pkg::OPC_OP: begin
            rd_wr = 1'b1;
            if (funct7 == exu_pkg::F7_BASE) begin
               alu_op = base_op;
            end else if ((funct7 == exu_pkg::F7_ALT) && has_alt) begin
               alu_op = alt_op;
            end else begin
               illegal = 1'b1;
            end
         end
         exu_pkg::OPC_OPIMM: begin
            rd_wr    = 1'b1;
            opr2_imm = 1'b1;
            alu_op   = base_op;
            // Shift immediates keep funct7 in the upper imm bits
            if (funct3 == exu_pkg::F3_SLL) begin
               illegal = (funct7 != exu_pkg::F7_BASE);
            end else if (funct3 == exu_pkg::F3_SRL_SRA) begin
               if (funct7 == exu_pkg::F7_ALT) begin
                  alu_op = exu_pkg::ALU_SRA;
               end else if (funct7 != exu_pkg::F7_BASE) begin
                  illegal = 1'b1;
               end
            end
         end
         exu_pkg::OPC_LUI: begin
            rd_wr    = 1'b1;
            opr2_imm = 1'b1;
            imm      = imm_u_type;
            alu_op   = exu_pkg::ALU_PASS2;
         end
         exu_pkg::OPC_AUIPC: begin
            rd_wr    = 1'b1;
            opr1_pc  = 1'b1;
            opr2_imm = 1'b1;
            imm      = imm_u_type;
         end
         exu_pkg::OPC_JAL: begin
            rd_wr = 1'b1;
            jump  = 1'b1;
            imm   = imm_j_type;     // Link value comes from execute
         end
         exu_pkg::OPC_BRANCH: begin
            branch = 1'b1;
            imm    = imm_b_type;
            case (funct3)
               exu_pkg::BR_BEQ, exu_pkg::BR_BNE, exu_pkg::BR_BLT,
               exu_pkg::BR_BGE, exu_pkg::BR_BLTU, exu_pkg::BR_BGEU: ;
               default: illegal = 1'b1;
            endcase
         end
         default: illegal = 1'b1;
      endcase

      // Illegal words retire with no side effects
      if (illegal) begin
         rd_wr  = 1'b0;
         branch = 1'b0;
         jump   = 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         de_valid_o <= 1'b0;
      end else begin
         de_valid_o <= instr_valid_i;
      end
   end

   // Stage payload, qualified by de_valid_o downstream
   always_ff @(posedge clk_i) begin
      if (instr_valid_i) begin
         de_pc_o       <= pc_i;
         de_imm_o      <= imm;
         de_rs1_data_o <= rs1_data_i;
         de_rs2_data_o <= rs2_data_i;
         de_rs1_addr_o <= rs1_addr_o;
         de_rs2_addr_o <= rs2_addr_o;
         de_rd_o       <= instr_i[11:7];
         de_alu_op_o   <= alu_op;
         de_opr1_pc_o  <= opr1_pc;
         de_opr2_imm_o <= opr2_imm;
         de_rd_wr_o    <= rd_wr;
         de_branch_o   <= branch;
         de_jump_o     <= jump;
         de_illegal_o  <= illegal;
         de_br_op_o    <= funct3;
      end
   end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module reg_file (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  exu_pkg::reg_addr_t rd_addr_a_i,
   input  exu_pkg::reg_addr_t rd_addr_b_i,
   output exu_pkg::data_t     rd_data_a_o,
   output exu_pkg::data_t     rd_data_b_o,
   input  logic               wr_en_i,
   input  exu_pkg::reg_addr_t wr_addr_i,
   input  exu_pkg::data_t     wr_data_i
);

   exu_pkg::data_t regs [`NUM_REGS];

   // x0 is never written, so it stays at its reset value
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i && (wr_addr_i != '0)) begin
         regs[wr_addr_i] <= wr_data_i;
      end
   end

   // Write data bypasses the array for same-cycle reads
   always_comb begin
      if (rd_addr_a_i == '0) begin
         rd_data_a_o = '0;
      end else if (wr_en_i && (wr_addr_i == rd_addr_a_i)) begin
         rd_data_a_o = wr_data_i;
      end else begin
         rd_data_a_o = regs[rd_addr_a_i];
      end

      if (rd_addr_b_i == '0) begin
         rd_data_b_o = '0;
      end else if (wr_en_i && (wr_addr_i == rd_addr_b_i)) begin
         rd_data_b_o = wr_data_i;
      end else begin
         rd_data_b_o = regs[rd_addr_b_i];
      end
   end

endmodule

`default_nettype wire

//--- include/exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// Widths fixed by RV32I

// Data path width for operands, results and PCs
`define XLEN     32

// Register index width
`define REG_AW   5

// Architectural register count, x0 included
`define NUM_REGS 32

// ALU operation code width
`define ALU_OPW  4

`endif

//--- list.f
+incdir+include
design/exu_pkg.sv
design/instr_decode.sv
design/reg_file.sv
design/execute.sv
design/exu_top.sv
test/exu_props.sv
test/exu_tb.sv

//--- test/exu_props.sv
`timescale 1ns/1ps
`default_nettype none

module exu_props (
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               wb_valid_i,
   input exu_pkg::reg_addr_t wb_rd_i,
   input logic               redirect_valid_i,
   input logic               illegal_i
);

   // Strobes known once out of reset
   a_strobe_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !$isunknown({wb_valid_i, redirect_valid_i, illegal_i}))
      else $error("Retire strobe is unknown");

   a_wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_valid_i |-> (wb_rd_i != 5'd0))
      else $error("Writeback strobe with rd equal to x0");

   // Illegal words retire with no side effects
   a_illegal_no_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      illegal_i |-> !wb_valid_i)
      else $error("Illegal strobe together with writeback");

   a_illegal_no_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      illegal_i |-> !redirect_valid_i)
      else $error("Illegal strobe together with redirect");

endmodule

bind exu_top exu_props props0 (
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .wb_valid_i       (wb_valid_o),
   .wb_rd_i          (wb_rd_o),
   .redirect_valid_i (redirect_valid_o),
   .illegal_i        (illegal_o)
);

`default_nettype wire

//--- test/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb;

   localparam int MAX_ENTRIES = 64;

   typedef struct packed {
      logic [31:0]        due;          // Cycle in which the strobes are expected
      logic               wb_valid;
      exu_pkg::reg_addr_t rd;
      exu_pkg::data_t     data;
      logic               redir;
      exu_pkg::data_t     target;
      logic               illegal;
   } pred_t;

   logic               clk_i;
   logic               rst_n_i;
   logic               instr_valid_i;
   exu_pkg::instr_t    instr_i;
   exu_pkg::data_t     pc_i;
   logic               wb_valid_o;
   exu_pkg::reg_addr_t wb_rd_o;
   exu_pkg::data_t     wb_data_o;
   logic               redirect_valid_o;
   exu_pkg::data_t     redirect_pc_o;
   logic               illegal_o;

   exu_pkg::instr_t instr_tab [MAX_ENTRIES];
   exu_pkg::data_t  pc_tab [MAX_ENTRIES];
   int              gap_tab [MAX_ENTRIES];    // Idle cycles after the entry
   int              n_entries = 0;
   exu_pkg::data_t  next_pc = 32'h0000_1000;
   exu_pkg::data_t  model_regs [32];
   pred_t           pred_q [$];
   pred_t           head;
   logic [31:0]     cyc = '0;
   logic [31:0]     limit = 32'd100000;
   logic            checking = 1'b0;
   int              seed = 32'h2809bf95;

   exu_top dut0 (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .instr_valid_i    (instr_valid_i),
      .instr_i          (instr_i),
      .pc_i             (pc_i),
      .wb_valid_o       (wb_valid_o),
      .wb_rd_o          (wb_rd_o),
      .wb_data_o        (wb_data_o),
      .redirect_valid_o (redirect_valid_o),
      .redirect_pc_o    (redirect_pc_o),
      .illegal_o        (illegal_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at time %0t", $time);
   endtask

   task automatic check_data(input string name, input exu_pkg::data_t exp,
                             input exu_pkg::data_t act);
      if (act !== exp) begin
         $display("[FAIL] time %0t %s expected %h got %h", $time, name, exp, act);
         stop_run("Mismatch on a retire output");
      end
   endtask

   task automatic check_addr(input string name, input exu_pkg::reg_addr_t exp,
                             input exu_pkg::reg_addr_t act);
      if (act !== exp) begin
         $display("[FAIL] time %0t %s expected %0d got %0d", $time, name, exp, act);
         stop_run("Mismatch on a retire output");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[FAIL] time %0t %s expected %b got %b", $time, name, exp, act);
         stop_run("Mismatch on a retire strobe");
      end
   endtask

   function automatic exu_pkg::instr_t r_word(input logic [6:0] f7,
         input exu_pkg::reg_addr_t rs2, input exu_pkg::reg_addr_t rs1,
         input logic [2:0] f3, input exu_pkg::reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, exu_pkg::OPC_OP};
   endfunction

   function automatic exu_pkg::instr_t i_word(input logic [11:0] imm,
         input exu_pkg::reg_addr_t rs1, input logic [2:0] f3, input exu_pkg::reg_addr_t rd);
      return {imm, rs1, f3, rd, exu_pkg::OPC_OPIMM};
   endfunction

   function automatic exu_pkg::instr_t u_word(input logic [6:0] opc, input logic [19:0] imm,
                                              input exu_pkg::reg_addr_t rd);
      return {imm, rd, opc};
   endfunction

   function automatic exu_pkg::instr_t b_word(input logic [12:0] imm,
         input exu_pkg::reg_addr_t rs2, input exu_pkg::reg_addr_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], exu_pkg::OPC_BRANCH};
   endfunction

   function automatic exu_pkg::instr_t j_word(input logic [20:0] imm,
                                              input exu_pkg::reg_addr_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, exu_pkg::OPC_JAL};
   endfunction

   // RV32I integer semantics by funct3
   function automatic exu_pkg::data_t rv_alu(input logic [2:0] f3, input logic alt,
                                             input exu_pkg::data_t a, input exu_pkg::data_t b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b011:  return (a < b) ? 32'd1 : 32'd0;
         3'b100:  return a ^ b;
         3'b101:  return alt ? exu_pkg::data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   // Reference model, one call per issued instruction in program order
   task automatic predict(input exu_pkg::instr_t w, input exu_pkg::data_t pc,
                          input logic [31:0] due);
      logic [6:0]         opc;
      logic [2:0]         f3;
      logic [6:0]         f7;
      exu_pkg::reg_addr_t rd;
      exu_pkg::data_t     a;
      exu_pkg::data_t     b;
      exu_pkg::data_t     res;
      logic               legal;
      logic               wr;
      logic               taken;
      pred_t              p;
      opc   = w[6:0];
      f3    = w[14:12];
      f7    = w[31:25];
      rd    = w[11:7];
      a     = model_regs[w[19:15]];
      b     = model_regs[w[24:20]];
      p     = '0;
      p.due = due;
      legal = 1'b1;
      wr    = 1'b0;
      taken = 1'b0;
      res   = '0;
      case (opc)
         exu_pkg::OPC_OP: begin
            wr    = 1'b1;
            legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101)));
            res   = rv_alu(f3, f7 == 7'h20, a, b);
         end
         exu_pkg::OPC_OPIMM: begin
            wr = 1'b1;
            b  = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'b001) begin
               legal = (f7 == 7'h00);
            end else if (f3 == 3'b101) begin
               legal = (f7 == 7'h00) || (f7 == 7'h20);
            end
            res = rv_alu(f3, (f3 == 3'b101) && (f7 == 7'h20), a, b);
         end
         exu_pkg::OPC_LUI: begin
            wr  = 1'b1;
            res = {w[31:12], 12'b0};
         end
         exu_pkg::OPC_AUIPC: begin
            wr  = 1'b1;
            res = pc + {w[31:12], 12'b0};
         end
         exu_pkg::OPC_JAL: begin
            wr       = 1'b1;
            res      = pc + 32'd4;
            p.redir  = 1'b1;
            p.target = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         end
         exu_pkg::OPC_BRANCH: begin
            case (f3)
               3'b000:  taken = (a == b);
               3'b001:  taken = (a != b);
               3'b100:  taken = $signed(a) < $signed(b);
               3'b101:  taken = $signed(a) >= $signed(b);
               3'b110:  taken = a < b;
               3'b111:  taken = a >= b;
               default: legal = 1'b0;
            endcase
            p.redir  = legal && taken;
            p.target = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         end
         default: legal = 1'b0;
      endcase
      if (!legal) begin
         p.illegal = 1'b1;
         p.redir   = 1'b0;
      end else if (wr && (rd != 5'd0)) begin
         p.wb_valid     = 1'b1;
         p.rd           = rd;
         p.data         = res;
         model_regs[rd] = res;
      end
      pred_q.push_back(p);
   endtask

   task automatic add_entry(input exu_pkg::instr_t w, input int gap);
      instr_tab[n_entries] = w;
      pc_tab[n_entries]    = next_pc;
      gap_tab[n_entries]   = gap;
      n_entries++;
      next_pc += 32'd4;
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      logic [11:0] imm;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      // x1 negative and x2 positive, dependent ADDI right behind each LUI
      rnd = $random(seed);
      add_entry(u_word(exu_pkg::OPC_LUI, rnd[31:12] | 20'h80000, 5'd1), 0);
      add_entry(i_word(rnd[11:0], 5'd1, 3'b000, 5'd1), 1);
      rnd = $random(seed);
      add_entry(u_word(exu_pkg::OPC_LUI, rnd[31:12] & 20'h7ffff, 5'd2), 1);
      add_entry(i_word(rnd[11:0], 5'd2, 3'b000, 5'd2), 2);
      add_entry(i_word(12'd13, 5'd0, 3'b000, 5'd3), 0);
      for (int f = 0; f < 8; f++) begin
         add_entry(r_word(7'h00, 5'd2, 5'd1, f[2:0], 5'd4 + f[4:0]), f % 3);
      end
      add_entry(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd12), 0);   // SUB
      add_entry(r_word(7'h20, 5'd3, 5'd1, 3'b101, 5'd13), 1);   // SRA of a negative value
      for (int f = 0; f < 8; f++) begin
         imm = ((f == 1) || (f == 5)) ? 12'd7 : 12'h9a5;
         add_entry(i_word(imm, 5'd1, f[2:0], 5'd14 + f[4:0]), (f + 1) % 3);
      end
      add_entry(i_word({7'h20, 5'd9}, 5'd1, 3'b101, 5'd22), 0); // SRAI
      // Dependence chain through forward, bypass and array
      add_entry(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd23), 0);
      add_entry(r_word(7'h20, 5'd1, 5'd23, 3'b000, 5'd24), 1);
      add_entry(r_word(7'h00, 5'd23, 5'd24, 3'b100, 5'd25), 2);
      add_entry(r_word(7'h00, 5'd24, 5'd25, 3'b110, 5'd26), 0);
      add_entry(r_word(7'h00, 5'd26, 5'd26, 3'b000, 5'd27), 1);
      add_entry(u_word(exu_pkg::OPC_LUI, 20'hfedcb, 5'd28), 0);
      add_entry(u_word(exu_pkg::OPC_AUIPC, 20'h00012, 5'd29), 1);
      add_entry(j_word(21'h000040, 5'd30), 0);
      add_entry(r_word(7'h00, 5'd29, 5'd30, 3'b000, 5'd31), 2);
      // Branches, x1 negative against x2 positive
      add_entry(b_word(13'd16, 5'd1, 5'd1, 3'b000), 0);         // Taken
      add_entry(b_word(13'h1ff8, 5'd2, 5'd1, 3'b001), 1);       // Taken, backward
      add_entry(b_word(13'd32, 5'd2, 5'd1, 3'b100), 0);         // Taken
      add_entry(b_word(13'd32, 5'd2, 5'd1, 3'b101), 2);
      add_entry(b_word(13'd64, 5'd2, 5'd1, 3'b110), 0);
      add_entry(b_word(13'h1f00, 5'd2, 5'd1, 3'b111), 1);       // Taken
      add_entry(b_word(13'd8, 5'd2, 5'd1, 3'b000), 0);
      add_entry(i_word(12'd0, 5'd3, 3'b000, 5'd5), 0);          // x5 takes the value of x3
      add_entry(b_word(13'd12, 5'd3, 5'd5, 3'b000), 1);         // Taken only with forwarded x5
      // x0 as a destination
      add_entry(i_word(12'd5, 5'd1, 3'b000, 5'd0), 0);
      add_entry(r_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd6), 0);
      add_entry(j_word(21'h000008, 5'd0), 2);
      // Unsupported encodings, each followed by a read of its rd
      add_entry({12'h004, 5'd1, 3'b010, 5'd4, 7'b0000011}, 0);
      add_entry(r_word(7'h00, 5'd0, 5'd4, 3'b000, 5'd10), 0);
      add_entry(r_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd8), 1);
      add_entry(r_word(7'h00, 5'd0, 5'd8, 3'b000, 5'd11), 0);
      add_entry(i_word({7'h20, 5'd3}, 5'd1, 3'b001, 5'd12), 2);
      add_entry(r_word(7'h00, 5'd0, 5'd12, 3'b000, 5'd15), 0);
      add_entry(b_word(13'd8, 5'd2, 5'd1, 3'b010), 1);
   endtask

   always @(posedge clk_i) begin
      cyc <= cyc + 32'd1;
      if (cyc > limit) begin
         stop_run("Timeout: the run went past its cycle limit");
      end
   end

   // Strobes are compared in the middle of the cycle
   always @(negedge clk_i) begin
      if (checking) begin
         if ((pred_q.size() > 0) && (pred_q[0].due == cyc)) begin
            head = pred_q.pop_front();
            check_bit("wb_valid_o", head.wb_valid, wb_valid_o);
            check_bit("redirect_valid_o", head.redir, redirect_valid_o);
            check_bit("illegal_o", head.illegal, illegal_o);
            if (head.wb_valid) begin
               check_addr("wb_rd_o", head.rd, wb_rd_o);
               check_data("wb_data_o", head.data, wb_data_o);
            end
            if (head.redir) begin
               check_data("redirect_pc_o", head.target, redirect_pc_o);
            end
         end else if (wb_valid_o || redirect_valid_o || illegal_o) begin
            stop_run("A retire strobe went high with no instruction due in this cycle");
         end
      end
   end

   initial begin
      instr_valid_i = 1'b0;
      instr_i       = '0;
      pc_i          = '0;
      rst_n_i       = 1'b0;
      build_table();
      limit = n_entries * 3 + 16 + 20;
      repeat (16) @(posedge clk_i);
      rst_n_i  <= 1'b1;
      checking <= 1'b1;
      for (int k = 0; k < n_entries; k++) begin
         @(posedge clk_i);
         instr_valid_i <= 1'b1;
         instr_i       <= instr_tab[k];
         pc_i          <= pc_tab[k];
         predict(instr_tab[k], pc_tab[k], cyc + 32'd3);
         for (int g = 0; g < gap_tab[k]; g++) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
         end
      end
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      repeat (4) @(posedge clk_i);
      if (pred_q.size() != 0) begin
         stop_run("Some instructions never reached their retire cycle");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
